// File: project.f
+incdir+tb
hdl/parking_pkg.sv
hdl/second_tick.sv
hdl/space_counter.sv
hdl/parking_registry.sv
hdl/gate_fsm.sv
hdl/parking_ctrl_top.sv
tb/parking_ctrl_tb.sv

// File: tb/parking_tb_table.svh
`ifndef PARKING_TB_TABLE_SVH
`define PARKING_TB_TABLE_SVH

// Columns: name, operation, class nibble, ID tag, floor, expected msg,
// then the expected spec0, norm0 and flr1 counts after the step
task automatic load_table();
    // Normal IDs fill floor 0, then spill over to floor 1
    add_step("norm0_first",      OP_ENTRY,     4'h1, 0,  1'b0, MSG_GRANTED,     2, 2, 5);
    add_step("norm0_second",     OP_ENTRY,     4'h5, 1,  1'b0, MSG_GRANTED,     2, 1, 5);
    add_step("norm0_last",       OP_ENTRY,     4'h9, 2,  1'b0, MSG_GRANTED,     2, 0, 5);
    add_step("norm0_to_alt",     OP_ENTRY,     4'h3, 3,  1'b0, MSG_GRANTED_ALT, 2, 0, 4);
    // Special IDs use spec0 whatever floor they choose
    add_step("special_first",    OP_ENTRY,     4'hA, 4,  1'b0, MSG_GRANTED,     1, 0, 4);
    add_step("special_second",   OP_ENTRY,     4'hA, 5,  1'b1, MSG_GRANTED,     0, 0, 4);
    add_step("special_full",     OP_ENTRY,     4'hA, 6,  1'b0, MSG_FULL,        0, 0, 4);
    // Refused entries leave the counts alone
    add_step("class_zero",       OP_ENTRY,     4'h0, 7,  1'b0, MSG_DENIED,      0, 0, 4);
    add_step("class_f",          OP_ENTRY,     4'hF, 8,  1'b1, MSG_DENIED,      0, 0, 4);
    add_step("already_parked",   OP_ENTRY,     4'h1, 0,  1'b1, MSG_DENIED,      0, 0, 4);
    // Exits give back the kind that was allocated
    add_step("exit_alt_car",     OP_EXIT,      4'h3, 3,  1'b0, MSG_EXIT_OK,     0, 0, 5);
    add_step("exit_norm0_car",   OP_EXIT,      4'h5, 1,  1'b0, MSG_EXIT_OK,     0, 1, 5);
    add_step("exit_special_car", OP_EXIT,      4'hA, 4,  1'b0, MSG_EXIT_OK,     1, 1, 5);
    add_step("exit_unknown",     OP_EXIT,      4'h2, 9,  1'b0, MSG_DENIED,      1, 1, 5);
    // Fill floor 1, then the last floor-0 slot, then nothing is left
    add_step("flr1_fill_1",      OP_ENTRY,     4'h6, 10, 1'b1, MSG_GRANTED,     1, 1, 4);
    add_step("flr1_fill_2",      OP_ENTRY,     4'h6, 11, 1'b1, MSG_GRANTED,     1, 1, 3);
    add_step("flr1_fill_3",      OP_ENTRY,     4'h6, 12, 1'b1, MSG_GRANTED,     1, 1, 2);
    add_step("flr1_fill_4",      OP_ENTRY,     4'h6, 13, 1'b1, MSG_GRANTED,     1, 1, 1);
    add_step("flr1_fill_5",      OP_ENTRY,     4'h6, 14, 1'b1, MSG_GRANTED,     1, 1, 0);
    add_step("flr1_to_alt",      OP_ENTRY,     4'h7, 15, 1'b1, MSG_GRANTED_ALT, 1, 0, 0);
    add_step("normal_full",      OP_ENTRY,     4'h8, 16, 1'b0, MSG_FULL,        1, 0, 0);
    // Power drops during the grant hold
    add_step("power_drop",       OP_POWER_OFF, 4'hA, 17, 1'b0, MSG_BLANK,       0, 0, 0);
    add_step("exit_after_power", OP_EXIT,      4'hA, 17, 1'b0, MSG_EXIT_OK,     1, 0, 0);
endtask

`endif

// File: tb/parking_ctrl_tb.sv
module parking_ctrl_tb;
    import parking_pkg::*;

    typedef enum logic [1:0] {
        OP_ENTRY,
        OP_EXIT,
        OP_POWER_OFF
    } op_t;

    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_TAGS   = 32;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      power;
    logic      entry_req;
    park_req_t entry;
    logic      exit_req;
    park_id_t  exit_id;
    disp_msg_t msg;
    logic      power_led;
    logic      wrong_led;
    logic      green_led;
    spaces_t   spaces;

    string      step_name   [$];
    op_t        step_op     [$];
    logic [3:0] step_cls    [$];
    int         step_tag    [$];
    floor_t     step_flr    [$];
    disp_msg_t  step_msg    [$];
    spaces_t    step_spaces [$];

    // Random middle ID bits per tag
    logic [6:0] id_mid [NUM_TAGS];

    int mismatches = 0;
    int timeouts   = 0;

    parking_ctrl_top #(
        .CLKS_PER_SEC (20)
    ) u_parking_ctrl_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .power     (power),
        .entry_req (entry_req),
        .entry     (entry),
        .exit_req  (exit_req),
        .exit_id   (exit_id),
        .msg       (msg),
        .power_led (power_led),
        .wrong_led (wrong_led),
        .green_led (green_led),
        .spaces    (spaces)
    );

    always #5 clk = ~clk;

    function automatic spaces_t make_spaces(int spec0, int norm0, int flr1);
        spaces_t s;
        s.spec0 = space_cnt_t'(spec0);
        s.norm0 = space_cnt_t'(norm0);
        s.flr1  = space_cnt_t'(flr1);
        return s;
    endfunction

    function automatic string spaces_str(spaces_t s);
        return $sformatf("%0d/%0d/%0d", s.spec0, s.norm0, s.flr1);
    endfunction

    task automatic add_step(input string name, input op_t op, input logic [3:0] cls,
                            input int tag, input floor_t flr, input disp_msg_t exp_msg,
                            input int exp_spec0, input int exp_norm0, input int exp_flr1);
        step_name.push_back(name);
        step_op.push_back(op);
        step_cls.push_back(cls);
        step_tag.push_back(tag);
        step_flr.push_back(flr);
        step_msg.push_back(exp_msg);
        step_spaces.push_back(make_spaces(exp_spec0, exp_norm0, exp_flr1));
    endtask

    `include "parking_tb_table.svh"

    task automatic report_mismatch(input string test, input string what,
                                   input string exp_s, input string act_s);
        $display("** Error %s %s: expected %s, actual %s", test, what, exp_s, act_s);
        mismatches++;
    endtask

    // LEDs follow from the message shown
    task automatic check_outputs(input string test, input disp_msg_t exp_msg,
                                 input spaces_t exp_spaces);
        logic exp_power;
        logic exp_green;
        logic exp_wrong;
        exp_power = (exp_msg != MSG_BLANK);
        exp_green = (exp_msg == MSG_GRANTED) || (exp_msg == MSG_GRANTED_ALT) ||
                    (exp_msg == MSG_EXIT_OK);
        exp_wrong = (exp_msg == MSG_DENIED);
        if (msg !== exp_msg) begin
            report_mismatch(test, "msg", exp_msg.name(), msg.name());
        end
        if (spaces !== exp_spaces) begin
            report_mismatch(test, "spaces", spaces_str(exp_spaces), spaces_str(spaces));
        end
        if (power_led !== exp_power) begin
            report_mismatch(test, "power_led", $sformatf("%b", exp_power),
                            $sformatf("%b", power_led));
        end
        if (green_led !== exp_green) begin
            report_mismatch(test, "green_led", $sformatf("%b", exp_green),
                            $sformatf("%b", green_led));
        end
        if (wrong_led !== exp_wrong) begin
            report_mismatch(test, "wrong_led", $sformatf("%b", exp_wrong),
                            $sformatf("%b", wrong_led));
        end
    endtask

    task automatic wait_welcome(input string test, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (msg == MSG_WELCOME) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout in %s: the gate did not return to the welcome message", test);
            timeouts++;
        end
    endtask

    task automatic run_step(input int i, output bit ok);
        park_id_t id;
        id = {step_cls[i], id_mid[step_tag[i]], 5'(step_tag[i])};
        @(posedge clk);
        if (step_op[i] == OP_EXIT) begin
            exit_req <= 1'b1;
            exit_id  <= id;
        end else begin
            entry_req <= 1'b1;
            entry.id  <= id;
            entry.flr <= step_flr[i];
        end
        @(posedge clk);
        entry_req <= 1'b0;
        exit_req  <= 1'b0;
        // Result state and count update land on this edge
        @(posedge clk);
        if (step_op[i] == OP_POWER_OFF) begin
            power <= 1'b0;
            @(posedge clk);
        end
        @(negedge clk);
        check_outputs(step_name[i], step_msg[i], step_spaces[i]);
        if (step_op[i] == OP_POWER_OFF) begin
            @(posedge clk);
            power <= 1'b1;
        end
        wait_welcome(step_name[i], ok);
    endtask

    initial begin
        bit ok;
        void'($urandom(32'h49dd));
        for (int t = 0; t < NUM_TAGS; t++) begin
            id_mid[t] = 7'($urandom());
        end
        rst_n     <= 1'b0;
        power     <= 1'b0;
        entry_req <= 1'b0;
        entry     <= '0;
        exit_req  <= 1'b0;
        exit_id   <= '0;
        load_table();

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_outputs("reset_power_low", MSG_BLANK, make_spaces(2, 3, 5));

        @(posedge clk);
        power <= 1'b1;
        wait_welcome("power_up", ok);
        if (ok) begin
            check_outputs("power_up", MSG_WELCOME, make_spaces(2, 3, 5));
            for (int i = 0; i < step_name.size(); i++) begin
                run_step(i, ok);
                if (!ok) begin
                    break;
                end
            end
        end

        $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if ((mismatches == 0) && (timeouts == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hdl/parking_ctrl_top.sv
module parking_ctrl_top #(
    parameter int CLKS_PER_SEC = parking_pkg::CLKS_PER_SEC
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   power,
    input  logic                   entry_req,
    input  parking_pkg::park_req_t entry,
    input  logic                   exit_req,
    input  parking_pkg::park_id_t  exit_id,
    output parking_pkg::disp_msg_t msg,
    output logic                   power_led,
    output logic                   wrong_led,
    output logic                   green_led,
    output parking_pkg::spaces_t   spaces
);
    import parking_pkg::*;

    logic       tick;
    logic       hit;
    slot_kind_t hit_kind;
    park_id_t   lookup_id;
    logic       alloc;
    logic       release_slot;
    slot_kind_t alloc_kind;
    slot_kind_t release_kind;
    logic       insert;
    logic       remove;

    gate_fsm u_gate_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .power        (power),
        .entry_req    (entry_req),
        .entry        (entry),
        .exit_req     (exit_req),
        .exit_id      (exit_id),
        .tick         (tick),
        .spaces       (spaces),
        .hit          (hit),
        .hit_kind     (hit_kind),
        .lookup_id    (lookup_id),
        .alloc        (alloc),
        .release_slot (release_slot),
        .alloc_kind   (alloc_kind),
        .release_kind (release_kind),
        .insert       (insert),
        .remove       (remove),
        .msg          (msg),
        .power_led    (power_led),
        .wrong_led    (wrong_led),
        .green_led    (green_led)
    );

    space_counter u_space_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .alloc_kind   (alloc_kind),
        .release_slot (release_slot),
        .release_kind (release_kind),
        .spaces       (spaces)
    );

    // Registry stores the kind chosen for the allocation
    parking_registry u_parking_registry (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_id   (lookup_id),
        .insert      (insert),
        .remove      (remove),
        .insert_kind (alloc_kind),
        .hit         (hit),
        .hit_kind    (hit_kind)
    );

    second_tick #(
        .CLKS_PER_SEC (CLKS_PER_SEC)
    ) u_second_tick (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

endmodule

// File: hdl/gate_fsm.sv
module gate_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    power,
    input  logic                    entry_req,
    input  parking_pkg::park_req_t  entry,
    input  logic                    exit_req,
    input  parking_pkg::park_id_t   exit_id,
    input  logic                    tick,
    input  parking_pkg::spaces_t    spaces,
    input  logic                    hit,
    input  parking_pkg::slot_kind_t hit_kind,
    output parking_pkg::park_id_t   lookup_id,
    output logic                    alloc,
    output logic                    release_slot,
    output parking_pkg::slot_kind_t alloc_kind,
    output parking_pkg::slot_kind_t release_kind,
    output logic                    insert,
    output logic                    remove,
    output parking_pkg::disp_msg_t  msg,
    output logic                    power_led,
    output logic                    wrong_led,
    output logic                    green_led
);
    import parking_pkg::*;

    typedef enum logic [3:0] {
        OFF,
        IDLE,
        CHECK_ENTRY,
        CHECK_EXIT,
        GRANTED,
        GRANTED_ALT,
        DENIED,
        NO_SPACE,
        EXIT_OK
    } gate_state_t;

    gate_state_t state;
    gate_state_t state_nxt;
    gate_state_t entry_result;
    park_req_t   req_q;
    logic        accept;
    logic [3:0]  id_class;
    logic        is_special;
    logic        is_normal;
    space_cnt_t  chosen_cnt;
    space_cnt_t  other_cnt;
    slot_kind_t  chosen_kind;
    slot_kind_t  other_kind;
    slot_kind_t  entry_kind;
    logic [2:0]  sec_cnt;
    logic [2:0]  hold_last;

    // Entry has priority over exit
    assign accept = power && (state == IDLE) && (entry_req || exit_req);

    always_ff @(posedge clk) begin
        if (accept) begin
            if (entry_req) begin
                req_q <= entry;
            end else begin
                req_q <= '{id: exit_id, flr: 1'b0};
            end
        end
    end

    assign lookup_id  = req_q.id;
    assign id_class   = req_q.id[15:12];
    assign is_special = (id_class == SPECIAL_CLASS);
    assign is_normal  = (id_class >= NORMAL_CLASS_MIN) && (id_class <= NORMAL_CLASS_MAX);

    always_comb begin
        if (req_q.flr == 1'b0) begin
            chosen_cnt  = spaces.norm0;
            chosen_kind = SLOT_FLOOR0;
            other_cnt   = spaces.flr1;
            other_kind  = SLOT_FLOOR1;
        end else begin
            chosen_cnt  = spaces.flr1;
            chosen_kind = SLOT_FLOOR1;
            other_cnt   = spaces.norm0;
            other_kind  = SLOT_FLOOR0;
        end
    end

    // Classify the ID and pick a slot
    always_comb begin
        entry_kind = chosen_kind;
        if ((!is_special && !is_normal) || hit) begin
            entry_result = DENIED;
        end else if (is_special) begin
            entry_kind   = SLOT_SPECIAL;
            entry_result = (spaces.spec0 != '0) ? GRANTED : NO_SPACE;
        end else if (chosen_cnt != '0) begin
            entry_result = GRANTED;
        end else if (other_cnt != '0) begin
            entry_kind   = other_kind;
            entry_result = GRANTED_ALT;
        end else begin
            entry_result = NO_SPACE;
        end
    end

    always_comb begin
        state_nxt    = state;
        alloc        = 1'b0;
        release_slot = 1'b0;
        if (!power) begin
            state_nxt = OFF;
        end else begin
            case (state)
                OFF: state_nxt = IDLE;
                IDLE: begin
                    if (entry_req) begin
                        state_nxt = CHECK_ENTRY;
                    end else if (exit_req) begin
                        state_nxt = CHECK_EXIT;
                    end
                end
                CHECK_ENTRY: begin
                    state_nxt = entry_result;
                    alloc     = (entry_result == GRANTED) || (entry_result == GRANTED_ALT);
                end
                CHECK_EXIT: begin
                    state_nxt    = hit ? EXIT_OK : DENIED;
                    release_slot = hit;
                end
                // Result states hold for a number of ticks
                default: begin
                    if (tick && (sec_cnt == hold_last)) begin
                        state_nxt = IDLE;
                    end
                end
            endcase
        end
    end

    assign alloc_kind   = entry_kind;
    assign release_kind = hit_kind;
    assign insert       = alloc;
    assign remove       = release_slot;

    assign hold_last = ((state == DENIED) || (state == NO_SPACE)) ? 3'(DENY_SECS - 1)
                                                                   : 3'(GRANT_SECS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= OFF;
            sec_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state) begin
                sec_cnt <= '0;
            end else if (tick) begin
                sec_cnt <= sec_cnt + 3'd1;
            end
        end
    end

    always_comb begin
        power_led = (state != OFF);
        wrong_led = (state == DENIED);
        green_led = (state == GRANTED) || (state == GRANTED_ALT) || (state == EXIT_OK);
        case (state)
            OFF:         msg = MSG_BLANK;
            GRANTED:     msg = MSG_GRANTED;
            GRANTED_ALT: msg = MSG_GRANTED_ALT;
            DENIED:      msg = MSG_DENIED;
            NO_SPACE:    msg = MSG_FULL;
            EXIT_OK:     msg = MSG_EXIT_OK;
            default:     msg = MSG_WELCOME;
        endcase
    end

    // Each update pulse follows the strobe accepted one cycle earlier
    a_alloc_after_entry: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> $past(accept && entry_req));

    // Entry wins a tie, so a release never meets an alloc
    a_release_after_exit: assert property (@(posedge clk) disable iff (!rst_n)
        release_slot |-> $past(accept && !entry_req));

endmodule

// File: hdl/parking_registry.sv
module parking_registry (
    input  logic                    clk,
    input  logic                    rst_n,
    input  parking_pkg::park_id_t   lookup_id,
    input  logic                    insert,
    input  logic                    remove,
    input  parking_pkg::slot_kind_t insert_kind,
    output logic                    hit,
    output parking_pkg::slot_kind_t hit_kind
);
    import parking_pkg::*;

    localparam int IDX_W = $clog2(REG_DEPTH);

    logic [REG_DEPTH-1:0] valid;
    park_id_t             ids   [REG_DEPTH];
    slot_kind_t           kinds [REG_DEPTH];
    logic [REG_DEPTH-1:0] match;
    logic [IDX_W-1:0]     free_idx;
    logic                 full;

    always_comb begin
        for (int i = 0; i < REG_DEPTH; i++) begin
            match[i] = valid[i] && (ids[i] == lookup_id);
        end
    end

    assign hit  = |match;
    assign full = &valid;

    // Lowest matching entry wins
    always_comb begin
        hit_kind = SLOT_SPECIAL;
        for (int i = REG_DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_kind = kinds[i];
            end
        end
    end

    // Lowest free entry
    always_comb begin
        free_idx = '0;
        for (int i = REG_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (remove) begin
                valid <= valid & ~match;
            end
            if (insert) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            ids[free_idx]   <= lookup_id;
            kinds[free_idx] <= insert_kind;
        end
    end

    // Capacity checks upstream keep the table from overflowing
    a_no_insert_full: assert property (@(posedge clk) disable iff (!rst_n)
        insert |-> !full);

    a_no_insert_dup: assert property (@(posedge clk) disable iff (!rst_n)
        insert |-> !hit);

endmodule

// File: hdl/space_counter.sv
module space_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    alloc,
    input  parking_pkg::slot_kind_t alloc_kind,
    input  logic                    release_slot,
    input  parking_pkg::slot_kind_t release_kind,
    output parking_pkg::spaces_t    spaces
);
    import parking_pkg::*;

    logic dec_spec0;
    logic dec_norm0;
    logic dec_flr1;
    logic inc_spec0;
    logic inc_norm0;
    logic inc_flr1;

    function automatic space_cnt_t kind_cnt(spaces_t s, slot_kind_t k);
        case (k)
            SLOT_SPECIAL: return s.spec0;
            SLOT_FLOOR0:  return s.norm0;
            default:      return s.flr1;
        endcase
    endfunction

    function automatic space_cnt_t kind_cap(slot_kind_t k);
        case (k)
            SLOT_SPECIAL: return space_cnt_t'(CAP_SPEC0);
            SLOT_FLOOR0:  return space_cnt_t'(CAP_NORM0);
            default:      return space_cnt_t'(CAP_FLR1);
        endcase
    endfunction

    // Net change of one count
    function automatic space_cnt_t step(space_cnt_t cnt, logic dec, logic inc);
        if (dec && !inc) begin
            return cnt - 3'd1;
        end else if (inc && !dec) begin
            return cnt + 3'd1;
        end
        return cnt;
    endfunction

    assign dec_spec0 = alloc && (alloc_kind == SLOT_SPECIAL);
    assign dec_norm0 = alloc && (alloc_kind == SLOT_FLOOR0);
    assign dec_flr1  = alloc && (alloc_kind == SLOT_FLOOR1);
    assign inc_spec0 = release_slot && (release_kind == SLOT_SPECIAL);
    assign inc_norm0 = release_slot && (release_kind == SLOT_FLOOR0);
    assign inc_flr1  = release_slot && (release_kind == SLOT_FLOOR1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spaces.spec0 <= space_cnt_t'(CAP_SPEC0);
            spaces.norm0 <= space_cnt_t'(CAP_NORM0);
            spaces.flr1  <= space_cnt_t'(CAP_FLR1);
        end else begin
            spaces.spec0 <= step(spaces.spec0, dec_spec0, inc_spec0);
            spaces.norm0 <= step(spaces.norm0, dec_norm0, inc_norm0);
            spaces.flr1  <= step(spaces.flr1, dec_flr1, inc_flr1);
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> (kind_cnt(spaces, alloc_kind) != '0));

    // A release must match an earlier allocation
    a_no_release_full: assert property (@(posedge clk) disable iff (!rst_n)
        release_slot |-> (kind_cnt(spaces, release_kind) < kind_cap(release_kind)));

endmodule

// File: hdl/second_tick.sv
module second_tick #(
    parameter int CLKS_PER_SEC = parking_pkg::CLKS_PER_SEC
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);
    localparam int CNT_W = $clog2(CLKS_PER_SEC);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CNT_W'(CLKS_PER_SEC - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// File: hdl/parking_pkg.sv
package parking_pkg;

    // Bits 15:12 carry the class nibble
    typedef logic [15:0] park_id_t;

    // 0 is the ground floor
    typedef logic floor_t;

    typedef enum logic [1:0] {
        SLOT_SPECIAL,
        SLOT_FLOOR0,
        SLOT_FLOOR1
    } slot_kind_t;

    typedef logic [2:0] space_cnt_t;

    typedef struct packed {
        space_cnt_t spec0;
        space_cnt_t norm0;
        space_cnt_t flr1;
    } spaces_t;

    typedef struct packed {
        park_id_t id;
        floor_t   flr;
    } park_req_t;

    typedef enum logic [2:0] {
        MSG_BLANK,
        MSG_WELCOME,
        MSG_GRANTED,
        MSG_GRANTED_ALT,
        MSG_DENIED,
        MSG_FULL,
        MSG_EXIT_OK
    } disp_msg_t;

    // Slot capacities per kind
    localparam int CAP_SPEC0 = 2;
    localparam int CAP_NORM0 = 3;
    localparam int CAP_FLR1  = 5;
    localparam int REG_DEPTH = CAP_SPEC0 + CAP_NORM0 + CAP_FLR1;

    // ID classes
    localparam logic [3:0] SPECIAL_CLASS    = 4'hA;
    localparam logic [3:0] NORMAL_CLASS_MIN = 4'd1;
    localparam logic [3:0] NORMAL_CLASS_MAX = 4'd9;

    // Result hold times in seconds
    localparam int GRANT_SECS = 3;
    localparam int DENY_SECS  = 5;

    localparam int CLKS_PER_SEC = 50_000_000;

endpackage
